// File: Bender.yml
package:
  name: atom_io

sources:
  - atom_map_pkg.sv
  - atom_io_pkg.sv
  - atom_clken.sv
  - atom_bus_ctrl.sv
  - atom_bus_decode.sv
  - atom_pia.sv
  - atom_cassette.sv
  - atom_io_top.sv
  - target: simulation
    files:
      - tb_atom_io.sv

// File: atom_bus_ctrl.sv
// Bus cycle FSM, request and response handshakes around one CPU access slot
`timescale 1ns/1ps
`default_nettype none

module atom_bus_ctrl
(
   input  wire logic                              clk25,
   input  wire logic                              reset,
   input  wire logic                              cpu_clken,
   // Request channel
   input  wire logic                              req_valid,
   output logic                                   req_ready,
   input  wire logic                              req_write,
   input  wire logic [atom_map_pkg::ADDR_W-1:0]   req_addr,
   input  wire logic [atom_map_pkg::DATA_W-1:0]   req_wdata,
   // Response channel
   output logic                                   rsp_valid,
   input  wire logic                              rsp_ready,
   output logic      [atom_map_pkg::DATA_W-1:0]   rsp_rdata,
   // Access towards the decode
   output logic                                   access,
   output logic      [atom_map_pkg::ADDR_W-1:0]   acc_addr,
   output logic      [atom_map_pkg::DATA_W-1:0]   acc_wdata,
   output logic                                   acc_write,
   input  wire logic [atom_map_pkg::DATA_W-1:0]   rdata
);
   import atom_map_pkg::*;

   typedef enum logic [1:0] {IDLE, WAIT_EN, RESP} state_t;

   state_t state;
   state_t state_next;

   // One transaction in flight
   assign req_ready = (state == IDLE);
   assign rsp_valid = (state == RESP);

   // Access lands on the first enable after acceptance
   assign access = (state == WAIT_EN) && cpu_clken;

   always_comb
   begin
      state_next = state;
      case (state)
         IDLE:
            if (req_valid)
               state_next = WAIT_EN;
         WAIT_EN:
            if (cpu_clken)
               state_next = RESP;
         RESP:
            if (rsp_ready)
               state_next = IDLE;
         default:
            state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         state <= IDLE;
      else
         state <= state_next;
   end

   // Request fields held from acceptance to access
   always_ff @(posedge clk25)
   begin
      if (req_valid && req_ready)
      begin
         acc_addr  <= req_addr;
         acc_wdata <= req_wdata;
         acc_write <= req_write;
      end
   end

   // Read data captured in the access cycle, stable under back-pressure
   always_ff @(posedge clk25)
   begin
      if (access)
         rsp_rdata <= rdata;
   end

endmodule

`default_nettype wire

// File: atom_bus_decode.sv
// Address region decode, ROM write mask, read data mux and lock flag snoop
`timescale 1ns/1ps
`default_nettype none

module atom_bus_decode
(
   input  wire logic                              clk25,
   input  wire logic                              reset,
   input  wire logic                              access,
   input  wire logic [atom_map_pkg::ADDR_W-1:0]   acc_addr,
   input  wire logic [atom_map_pkg::DATA_W-1:0]   acc_wdata,
   input  wire logic                              acc_write,
   // External memory port
   output logic      [atom_map_pkg::ADDR_W-1:0]   mem_addr,
   output logic      [atom_map_pkg::DATA_W-1:0]   mem_wdata,
   output logic                                   mem_we,
   input  wire logic [atom_map_pkg::DATA_W-1:0]   mem_rdata,
   // PIA
   output logic                                   pia_sel,
   input  wire logic [atom_map_pkg::DATA_W-1:0]   pia_rdata,
   // Back to the controller
   output logic      [atom_map_pkg::DATA_W-1:0]   rdata,
   output logic                                   lock
);
   import atom_map_pkg::*;

   region_t           region;
   logic [DATA_W-1:0] unused_val;

   // ==================================================
   // Region decode
   // ==================================================

   // RAM, video RAM and ROM all sit on the one memory port
   always_comb
   begin
      if (acc_addr[15:14] == ROM_TAG)
         region = ROM;
      else if (acc_addr[15:10] == PIA_TAG)
         region = PIA;
      else if (acc_addr[15:10] == PL8_TAG)
         region = PL8;
      else if (acc_addr[15:11] == UNUSED_TAG)
         region = UNUSED;
      else
         region = MEM;
   end

   assign mem_addr  = acc_addr;
   assign mem_wdata = acc_wdata;

   // ROM writes never reach memory
   assign mem_we  = access && acc_write && (region == MEM);
   assign pia_sel = access && (region == PIA);

   // ==================================================
   // Read data mux
   // ==================================================

   // Floating bus, high address byte with some bits pulled down
   assign unused_val = acc_addr[ADDR_W-1 -: DATA_W] & UNUSED_MASK;

   always_comb
   begin
      case (region)
         MEM, ROM: rdata = mem_rdata;
         PIA:      rdata = pia_rdata;
         PL8:      rdata = '0;
         // UNUSED, old VIA and SPI space included
         default:  rdata = unused_val;
      endcase
   end

   // Snoop the lock flag on writes to E7
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         lock <= 1'b0;
      else if (access && acc_write && (acc_addr == LOCK_ADDR))
         lock <= acc_wdata[LOCK_BIT];
   end

endmodule

`default_nettype wire

// File: atom_cassette.sv
// Cassette tone divider, cassette output and sound
`timescale 1ns/1ps
`default_nettype none

module atom_cassette
(
   input  wire logic       clk25,
   input  wire logic       reset,
   input  wire logic       cpu_clken,
   input  wire logic [3:0] pc_low,
   output logic            cas_tone,
   output logic            cas_out,
   output logic            sound
);
   import atom_io_pkg::*;

   logic [CAS_W-1:0] cas_cnt;

   // Tone toggles every CAS_DIV CPU enables
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cas_cnt  <= '0;
         cas_tone <= 1'b0;
      end
      else if (cpu_clken)
      begin
         if (cas_cnt == CAS_W'(CAS_DIV - 1))
         begin
            cas_cnt  <= '0;
            cas_tone <= !cas_tone;
         end
         else
            cas_cnt <= cas_cnt + 1'b1;
      end
   end

   assign sound = pc_low[2];

   // Two NAND gates and an inverter, as on the board
   assign cas_out = !(pc_low[0] && !(pc_low[1] && !cas_tone));

endmodule

`default_nettype wire

// File: atom_clken.sv
// CPU clock enable divider, 1/2/4/8 accesses per 25 cycle frame
`timescale 1ns/1ps
`default_nettype none

module atom_clken
(
   input  wire logic                 clk25,
   input  wire logic                 reset,
   input  wire atom_map_pkg::turbo_t turbo,
   output logic                      cpu_clken
);
   import atom_map_pkg::*;
   import atom_io_pkg::*;

   logic [FRAME_W-1:0] frame_cnt;
   logic               active;
   logic               en_next;

   // Enables only fall in the first part of the frame
   assign active = (frame_cnt < FRAME_W'(CLK_ACTIVE));

   // Spacing of the enables halves with each speed step
   always_comb
   begin
      case (turbo)
         SPEED_1M: en_next = active && (frame_cnt[3:0] == 4'd0);
         SPEED_2M: en_next = active && (frame_cnt[2:0] == 3'd0);
         SPEED_4M: en_next = active && (frame_cnt[1:0] == 2'd0);
         SPEED_8M: en_next = active && (frame_cnt[0] == 1'b0);
         default:  en_next = 1'b0;
      endcase
   end

   // Frame counter 0..24 and registered enable
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         frame_cnt <= '0;
         cpu_clken <= 1'b0;
      end
      else
      begin
         if (frame_cnt == FRAME_W'(CLK_FRAME - 1))
            frame_cnt <= '0;
         else
            frame_cnt <= frame_cnt + 1'b1;
         cpu_clken <= en_next;
      end
   end

endmodule

`default_nettype wire

// File: atom_io_pkg.sv
// PIA register offsets, port C bit positions, cassette divider and clock frame
`default_nettype none

package atom_io_pkg;

   // 8255 register offsets on addr[1:0]
   typedef enum logic [1:0] {PIA_PA = 2'd0, PIA_PB = 2'd1, PIA_PC = 2'd2, PIA_CTRL = 2'd3}
      pia_reg_t;

   // Port C upper nibble, all inputs
   localparam int PC_TONE_BIT  = 4;
   localparam int PC_CASIN_BIT = 5;
   localparam int PC_REPT_BIT  = 6;
   localparam int PC_FS_BIT    = 7;

   // Tone half period in CPU enables, 208 = 16 * 13
   localparam int CAS_DIV = 208;
   localparam int CAS_W   = $clog2(CAS_DIV);

   // 25 MHz divided down in frames of 25 cycles
   localparam int CLK_FRAME  = 25;
   localparam int CLK_ACTIVE = 16;
   localparam int FRAME_W    = $clog2(CLK_FRAME);

endpackage

`default_nettype wire

// File: atom_io_top.sv
// Top level, bus port in place of the CPU, clock enable, decode, PIA and cassette
`timescale 1ns/1ps
`default_nettype none

module atom_io_top
(
   input  wire logic                              clk25,
   input  wire logic                              reset,
   input  wire atom_map_pkg::turbo_t              turbo,
   // Request channel
   input  wire logic                              req_valid,
   output logic                                   req_ready,
   input  wire logic                              req_write,
   input  wire logic [atom_map_pkg::ADDR_W-1:0]   req_addr,
   input  wire logic [atom_map_pkg::DATA_W-1:0]   req_wdata,
   // Response channel
   output logic                                   rsp_valid,
   input  wire logic                              rsp_ready,
   output logic      [atom_map_pkg::DATA_W-1:0]   rsp_rdata,
   // External memory, split data buses
   output logic      [atom_map_pkg::ADDR_W-1:0]   mem_addr,
   output logic      [atom_map_pkg::DATA_W-1:0]   mem_wdata,
   output logic                                   mem_we,
   input  wire logic [atom_map_pkg::DATA_W-1:0]   mem_rdata,
   // Keyboard and video
   input  wire logic [5:0]                        keyout,
   input  wire logic                              shift_n,
   input  wire logic                              ctrl_n,
   input  wire logic                              rept_n,
   input  wire logic                              fs_n,
   // Cassette and flags
   input  wire logic                              cas_in,
   output logic                                   cas_out,
   output logic                                   sound,
   output logic                                   lock,
   output logic                                   cpu_clken
);
   import atom_map_pkg::*;
   import atom_io_pkg::*;

   logic              access;
   logic [ADDR_W-1:0] acc_addr;
   logic [DATA_W-1:0] acc_wdata;
   logic              acc_write;
   logic [DATA_W-1:0] rdata;
   logic              pia_sel;
   logic [DATA_W-1:0] pia_rdata;
   logic [3:0]        pc_low;
   logic              cas_tone;

   atom_clken u_clken
   (
      .clk25     (clk25),
      .reset     (reset),
      .turbo     (turbo),
      .cpu_clken (cpu_clken)
   );

   atom_bus_ctrl u_bus_ctrl
   (
      .clk25     (clk25),
      .reset     (reset),
      .cpu_clken (cpu_clken),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_write (req_write),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_rdata (rsp_rdata),
      .access    (access),
      .acc_addr  (acc_addr),
      .acc_wdata (acc_wdata),
      .acc_write (acc_write),
      .rdata     (rdata)
   );

   atom_bus_decode u_bus_decode
   (
      .clk25     (clk25),
      .reset     (reset),
      .access    (access),
      .acc_addr  (acc_addr),
      .acc_wdata (acc_wdata),
      .acc_write (acc_write),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_we    (mem_we),
      .mem_rdata (mem_rdata),
      .pia_sel   (pia_sel),
      .pia_rdata (pia_rdata),
      .rdata     (rdata),
      .lock      (lock)
   );

   // Register select from the two low address bits
   atom_pia u_pia
   (
      .clk25     (clk25),
      .reset     (reset),
      .pia_sel   (pia_sel),
      .acc_write (acc_write),
      .pia_reg   (pia_reg_t'(acc_addr[1:0])),
      .acc_wdata (acc_wdata),
      .pia_rdata (pia_rdata),
      .keyout    (keyout),
      .shift_n   (shift_n),
      .ctrl_n    (ctrl_n),
      .rept_n    (rept_n),
      .fs_n      (fs_n),
      .cas_in    (cas_in),
      .cas_tone  (cas_tone),
      .pc_low    (pc_low)
   );

   atom_cassette u_cassette
   (
      .clk25     (clk25),
      .reset     (reset),
      .cpu_clken (cpu_clken),
      .pc_low    (pc_low),
      .cas_tone  (cas_tone),
      .cas_out   (cas_out),
      .sound     (sound)
   );

endmodule

`default_nettype wire

// File: atom_map_pkg.sv
// Memory map constants, address region enum and turbo speed enum
`default_nettype none

package atom_map_pkg;

   // Bus widths seen by the external master
   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   // ==================================================
   // Address map tags
   // ==================================================

   // C000-FFFF ROM, matched on addr[15:14]
   localparam logic [1:0] ROM_TAG    = 2'b11;
   // B000-B3FF 8255 PIA, matched on addr[15:10]
   localparam logic [5:0] PIA_TAG    = 6'b101100;
   // B400-B7FF empty, reads as zero
   localparam logic [5:0] PL8_TAG    = 6'b101101;
   // B800-BFFF old VIA and SPI space, matched on addr[15:11]
   localparam logic [4:0] UNUSED_TAG = 5'b10111;

   // Lock flag lives in bit 5 of zero page E7
   localparam logic [ADDR_W-1:0] LOCK_ADDR = 16'h00E7;
   localparam int                LOCK_BIT  = 5;

   // Floating bus value, bus capacitance and pull downs
   localparam logic [DATA_W-1:0] UNUSED_MASK = 8'hF1;

   typedef enum logic [2:0] {MEM, ROM, PIA, PL8, UNUSED} region_t;

   typedef enum logic [1:0] {SPEED_1M, SPEED_2M, SPEED_4M, SPEED_8M} turbo_t;

endpackage

`default_nettype wire

// File: atom_pia.sv
// 8255 PIA model, port A latch, port C low nibble, bit set/reset, keyboard on B
`timescale 1ns/1ps
`default_nettype none

module atom_pia
(
   input  wire logic                              clk25,
   input  wire logic                              reset,
   input  wire logic                              pia_sel,
   input  wire logic                              acc_write,
   input  wire atom_io_pkg::pia_reg_t             pia_reg,
   input  wire logic [atom_map_pkg::DATA_W-1:0]   acc_wdata,
   output logic      [atom_map_pkg::DATA_W-1:0]   pia_rdata,
   // Keyboard and video status
   input  wire logic [5:0]                        keyout,
   input  wire logic                              shift_n,
   input  wire logic                              ctrl_n,
   input  wire logic                              rept_n,
   input  wire logic                              fs_n,
   // Cassette
   input  wire logic                              cas_in,
   input  wire logic                              cas_tone,
   output logic      [3:0]                        pc_low
);
   import atom_map_pkg::*;
   import atom_io_pkg::*;

   logic [DATA_W-1:0] pa_q;
   logic [3:0]        pc_q;
   logic [DATA_W-1:0] pb_rd;
   logic [DATA_W-1:0] pc_rd;

   // Port directions are fixed, A and C low out, B and C high in
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         pa_q <= '0;
         pc_q <= '0;
      end
      else if (pia_sel && acc_write)
      begin
         case (pia_reg)
            PIA_PA: pa_q <= acc_wdata;
            PIA_PC: pc_q <= acc_wdata[3:0];
            // Bit set/reset on port C when bit 7 is clear
            PIA_CTRL:
               if (!acc_wdata[7])
                  pc_q[acc_wdata[2:1]] <= acc_wdata[0];
            default: ;
         endcase
      end
   end

   assign pb_rd = {shift_n, ctrl_n, keyout};

   always_comb
   begin
      pc_rd               = '0;
      pc_rd[3:0]          = pc_q;
      pc_rd[PC_TONE_BIT]  = cas_tone;
      pc_rd[PC_CASIN_BIT] = cas_in;
      pc_rd[PC_REPT_BIT]  = rept_n;
      pc_rd[PC_FS_BIT]    = fs_n;
   end

   always_comb
   begin
      case (pia_reg)
         PIA_PA:  pia_rdata = pa_q;
         PIA_PB:  pia_rdata = pb_rd;
         PIA_PC:  pia_rdata = pc_rd;
         default: pia_rdata = '0;
      endcase
   end

   assign pc_low = pc_q;

endmodule

`default_nettype wire

// File: sim.f
atom_map_pkg.sv
atom_io_pkg.sv
atom_clken.sv
atom_bus_ctrl.sv
atom_bus_decode.sv
atom_pia.sv
atom_cassette.sv
atom_io_top.sv
tb_atom_io.sv

// File: tb_atom_io.sv
// Testbench for atom_io_top with external memory model, LFSR stimulus,
// reference read model and bus protocol checks
`timescale 1ns/1ps
`default_nettype none

module tb_atom_io;
   import atom_map_pkg::*;

   // ==================================================
   // Test lengths and run limit
   // ==================================================
   localparam int N_MEM   = 48;
   localparam int N_FIXED = 32;
   localparam int N_PIA   = 12;
   localparam int N_CAS   = 8;
   localparam int N_TONE  = 3;
   localparam int N_LOCK  = 4;
   localparam int N_BP    = 64;
   localparam int TXN_TOTAL = 3 * N_MEM + N_FIXED + 7 * N_PIA + 2 * N_CAS + 1 + N_TONE
                              + 2 * N_LOCK + N_BP;
   // Worst access wait, longest response stall from the LFSR, handshake overhead
   localparam int TXN_CYCLES = 27 + 32 + 5;
   localparam int TONE_WAIT  = 700;
   localparam int EXTRA      = 3 + 4 * 104 + N_TONE * TONE_WAIT + 16;
   localparam int MAX_CYCLES = 2 * (TXN_TOTAL * TXN_CYCLES + EXTRA);
   localparam int TONE_DIV   = 208;
   localparam int DLY        = 2;

   logic        clk25;
   logic        reset;
   turbo_t      turbo;
   logic        req_valid;
   logic        req_ready;
   logic        req_write;
   logic [15:0] req_addr;
   logic [7:0]  req_wdata;
   logic        rsp_valid;
   logic        rsp_ready;
   logic [7:0]  rsp_rdata;
   logic [15:0] mem_addr;
   logic [7:0]  mem_wdata;
   logic        mem_we;
   logic [7:0]  mem_rdata;
   logic [5:0]  keyout;
   logic        shift_n;
   logic        ctrl_n;
   logic        rept_n;
   logic        fs_n;
   logic        cas_in;
   logic        cas_out;
   logic        sound;
   logic        lock;
   logic        cpu_clken;

   // Memory model and its expected image
   logic [7:0]  mem [0:65535];
   logic [7:0]  ref_mem [0:65535];

   // Expected PIA, lock and tone state
   logic [7:0]  pa_ref;
   logic [3:0]  pc_ref;
   logic        lock_ref;
   logic        tone_ref;
   int          tone_cnt;

   // Transaction tracking in the monitor
   logic        acc_wait;
   logic        acc_w;
   logic [15:0] acc_a;
   logic [7:0]  acc_d;
   logic        rsp_due;
   logic        took_rsp;
   logic        stalled;
   logic [7:0]  held_data;
   logic [15:0] exp_addr[$];
   logic        exp_rd[$];
   logic [7:0]  exp_val[$];

   logic [31:0] lfsr = 32'h6d03;
   logic        bp_on = 1'b0;
   int          issued = 0;
   int          completed = 0;
   int          checks = 0;
   int          errors = 0;
   int          cycle_cnt = 0;

   atom_io_top DUT
   (
      .clk25     (clk25),
      .reset     (reset),
      .turbo     (turbo),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_write (req_write),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_rdata (rsp_rdata),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_we    (mem_we),
      .mem_rdata (mem_rdata),
      .keyout    (keyout),
      .shift_n   (shift_n),
      .ctrl_n    (ctrl_n),
      .rept_n    (rept_n),
      .fs_n      (fs_n),
      .cas_in    (cas_in),
      .cas_out   (cas_out),
      .sound     (sound),
      .lock      (lock),
      .cpu_clken (cpu_clken)
   );

   // External memory with combinational read
   assign mem_rdata = mem[mem_addr];

   always @(posedge clk25)
   begin
      if (mem_we)
         mem[mem_addr] <= mem_wdata;
   end

   initial
   begin
      clk25 = 1'b0;
      forever #20 clk25 = !clk25;
   end

   // ==================================================
   // Random numbers, model rules and checks
   // ==================================================

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // Main memory is everything outside ROM and the B000-BFFF I/O page
   function automatic logic is_mem_addr(input logic [15:0] a);
      return (a[15:14] != 2'b11) && (a[15:12] != 4'hB);
   endfunction

   function automatic logic cas_out_rule(input logic [3:0] pc, input logic tone);
      if (!pc[0])
         return 1'b1;
      else if (!pc[1])
         return 1'b0;
      else
         return !tone;
   endfunction

   // Expected read data at the access cycle
   function automatic logic [7:0] predict_read(input logic [15:0] a);
      if (a[15:14] == 2'b11)
         return ref_mem[a];
      else if (a[15:10] == 6'b101100)
      begin
         case (a[1:0])
            2'd0:    return pa_ref;
            2'd1:    return {shift_n, ctrl_n, keyout};
            2'd2:    return {fs_n, rept_n, cas_in, tone_ref, pc_ref};
            default: return 8'h00;
         endcase
      end
      else if (a[15:10] == 6'b101101)
         return 8'h00;
      else if (a[15:11] == 5'b10111)
         return a[15:8] & 8'hF1;
      else
         return ref_mem[a];
   endfunction

   task automatic apply_write(input logic [15:0] a, input logic [7:0] d);
      if (is_mem_addr(a))
         ref_mem[a] = d;
      if (a == 16'h00E7)
         lock_ref = d[5];
      if (a[15:10] == 6'b101100)
      begin
         case (a[1:0])
            2'd0: pa_ref = d;
            2'd2: pc_ref = d[3:0];
            2'd3:
               if (!d[7])
                  pc_ref[d[2:1]] = d[0];
            default: ;
         endcase
      end
   endtask

   task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("[ERROR] %s got %h exp %h", name, got, exp);
      end
   endtask

   task automatic check_true(input logic cond, input string msg);
      checks++;
      assert (cond === 1'b1)
      else
      begin
         errors++;
         $display("Error: %s at %0t", msg, $time);
      end
   endtask

   // ==================================================
   // Bus master
   // ==================================================

   // One access that returns once its response is taken
   task automatic do_access(input logic w, input logic [15:0] a, input logic [7:0] d);
      req_write = w;
      req_addr  = a;
      req_wdata = d;
      req_valid = 1'b1;
      @(negedge clk25);
      while (!req_ready)
         @(negedge clk25);
      @(posedge clk25);
      #DLY;
      req_valid = 1'b0;
      issued++;
      @(negedge clk25);
      while (!(rsp_valid && rsp_ready))
         @(negedge clk25);
      @(posedge clk25);
      #DLY;
   endtask

   // Response stalls only while back-pressure is on
   initial
   begin
      logic [31:0] r;
      rsp_ready = 1'b1;
      forever
      begin
         @(posedge clk25);
         r = '1;
         if (bp_on)
            rand_bits(1, r);
         #DLY;
         rsp_ready = r[0];
      end
   end

   // ==================================================
   // Monitor and compare
   // ==================================================
   always @(negedge clk25)
   begin
      if (reset)
      begin
         pa_ref   = '0;
         pc_ref   = '0;
         lock_ref = 1'b0;
         tone_ref = 1'b0;
         tone_cnt = 0;
         acc_wait = 1'b0;
         rsp_due  = 1'b0;
         took_rsp = 1'b0;
         stalled  = 1'b0;
      end
      else
      begin
         // Port C driven outputs and the lock flag
         check_val("sound", sound, pc_ref[2]);
         check_val("cas_out", cas_out, cas_out_rule(pc_ref, tone_ref));
         check_val("lock", lock, lock_ref);
         check_true(!(rsp_valid && req_ready), "req_ready high with a response pending");
         if (stalled)
         begin
            check_true(rsp_valid, "rsp_valid dropped under back-pressure");
            check_val("rsp_rdata (held)", rsp_rdata, held_data);
         end
         if (rsp_due)
            check_true(rsp_valid, "rsp_valid did not rise the cycle after the access");
         if (acc_wait)
            check_true(!rsp_valid, "rsp_valid high before the access");
         if (took_rsp)
            check_true(req_ready, "req_ready not back the cycle after the response");
         if (mem_we)
            check_true(is_mem_addr(mem_addr), "mem_we high outside main memory");
         rsp_due   = 1'b0;
         took_rsp  = 1'b0;
         stalled   = rsp_valid && !rsp_ready;
         held_data = rsp_rdata;

         if (rsp_valid && rsp_ready)
         begin
            if (exp_val.size() == 0)
               check_true(1'b0, "response with no request outstanding");
            else
            begin
               if (exp_rd[0])
                  check_val($sformatf("rsp_rdata @%h", exp_addr[0]), rsp_rdata, exp_val[0]);
               void'(exp_addr.pop_front());
               void'(exp_rd.pop_front());
               void'(exp_val.pop_front());
               completed++;
               took_rsp = 1'b1;
            end
         end

         // Access falls on the first enable after the acceptance cycle
         if (acc_wait && cpu_clken)
         begin
            acc_wait = 1'b0;
            rsp_due  = 1'b1;
            exp_addr.push_back(acc_a);
            exp_rd.push_back(!acc_w);
            if (acc_w)
            begin
               exp_val.push_back(8'h00);
               apply_write(acc_a, acc_d);
            end
            else
               exp_val.push_back(predict_read(acc_a));
         end

         if (req_valid && req_ready)
         begin
            acc_wait = 1'b1;
            acc_w    = req_write;
            acc_a    = req_addr;
            acc_d    = req_wdata;
         end

         // Tone toggles after every 208 enables
         if (cpu_clken)
         begin
            if (tone_cnt == TONE_DIV - 1)
            begin
               tone_cnt = 0;
               tone_ref = !tone_ref;
            end
            else
               tone_cnt++;
         end
      end
   end

   always @(posedge clk25)
   begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("Timeout after %0d cycles, %0d of %0d responses seen",
                  cycle_cnt, completed, issued);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // ==================================================
   // Stimulus
   // ==================================================
   initial
   begin
      logic [31:0] r;
      logic [15:0] a;
      logic [15:0] b;
      logic [7:0]  d;
      int          n;

      reset     = 1'b1;
      turbo     = SPEED_8M;
      req_valid = 1'b0;
      req_write = 1'b0;
      req_addr  = '0;
      req_wdata = '0;
      keyout    = 6'h3F;
      shift_n   = 1'b1;
      ctrl_n    = 1'b1;
      rept_n    = 1'b1;
      fs_n      = 1'b1;
      cas_in    = 1'b0;

      // Seed memory so that every byte also depends on its address
      for (int i = 0; i < 65536; i++)
      begin
         rand_bits(8, r);
         mem[i]     = r[7:0] ^ i[15:8] ^ i[7:0];
         ref_mem[i] = mem[i];
      end

      repeat (3) @(posedge clk25);
      #DLY;
      reset = 1'b0;

      // Enable count over 4 frames for each speed
      for (int s = 0; s < 4; s++)
      begin
         turbo = turbo_t'(s);
         repeat (4) @(posedge clk25);
         n = 0;
         repeat (100)
         begin
            @(negedge clk25);
            if (cpu_clken)
               n++;
         end
         check_val($sformatf("cpu_clken count, turbo %0d", s), n, 4 << s);
         @(posedge clk25);
         #DLY;
      end

      // Main memory and ROM, write then read back
      for (int i = 0; i < N_MEM; i++)
      begin
         rand_bits(2, r);
         turbo = turbo_t'(r[1:0]);
         rand_bits(17, r);
         a = r[15:0];
         if (r[16])
            a[15:14] = 2'b11;
         else
         begin
            if (a[15:14] == 2'b11)
               a[15] = 1'b0;
            if (a[15:12] == 4'hB)
               a[12] = 1'b0;
         end
         rand_bits(8, r);
         do_access(1'b1, a, r[7:0]);
         do_access(1'b0, a, 8'h00);
         rand_bits(16, r);
         do_access(1'b0, r[15:0], 8'h00);
      end
      turbo = SPEED_8M;

      // Empty and floating-bus regions
      for (int i = 0; i < N_FIXED; i++)
      begin
         rand_bits(11, r);
         if (i[0])
            a = 16'hB400 | {6'b0, r[9:0]};
         else
            a = 16'hB800 | {5'b0, r[10:0]};
         do_access(1'b0, a, 8'h00);
      end

      // PIA registers across mirrors
      for (int i = 0; i < N_PIA; i++)
      begin
         rand_bits(8, r);
         b = 16'hB000 | {6'b0, r[7:0], 2'b00};
         rand_bits(8, r);
         do_access(1'b1, b | 16'd0, r[7:0]);
         do_access(1'b0, b | 16'd0, 8'h00);
         rand_bits(11, r);
         {fs_n, rept_n, cas_in} = r[10:8];
         do_access(1'b1, b | 16'd2, r[7:0]);
         do_access(1'b0, b | 16'd2, 8'h00);
         rand_bits(8, r);
         do_access(1'b1, b | 16'd3, r[7:0]);
         do_access(1'b0, b | 16'd2, 8'h00);
         rand_bits(8, r);
         {shift_n, ctrl_n, keyout} = r[7:0];
         do_access(1'b0, b | 16'd1, 8'h00);
      end

      // Cassette and sound for each port C low combination
      for (int i = 0; i < N_CAS; i++)
      begin
         rand_bits(1, r);
         d = {4'h0, r[0], i[2:0]};
         do_access(1'b1, 16'hB002, d);
         do_access(1'b0, 16'hB002, 8'h00);
      end
      // Tone through cas_out across several toggles
      do_access(1'b1, 16'hB002, 8'h03);
      for (int i = 0; i < N_TONE; i++)
      begin
         repeat (TONE_WAIT) @(posedge clk25);
         #DLY;
         do_access(1'b0, 16'hB002, 8'h00);
      end

      // Lock snoop on E7
      for (int i = 0; i < N_LOCK; i++)
      begin
         rand_bits(8, r);
         d = r[7:0];
         d[5] = !i[0];
         do_access(1'b1, 16'h00E7, d);
         do_access(1'b0, 16'h00E7, 8'h00);
      end

      // Random traffic with response stalls
      bp_on = 1'b1;
      for (int i = 0; i < N_BP; i++)
      begin
         rand_bits(2, r);
         turbo = turbo_t'(r[1:0]);
         rand_bits(25, r);
         do_access(r[24], r[15:0], r[23:16]);
      end
      bp_on = 1'b0;

      repeat (4) @(posedge clk25);
      check_true(exp_val.size() == 0, "responses still outstanding at the end");
      check_true(completed == issued, "number of responses differs from requests");

      // ROM writes must have left memory untouched
      for (int i = 0; i < 65536; i++)
      begin
         checks++;
         assert (mem[i] === ref_mem[i])
         else
         begin
            errors++;
            $display("[ERROR] mem[%h] got %h exp %h", i[15:0], mem[i], ref_mem[i]);
         end
      end

      $display("checks %0d, errors %0d, transactions %0d of %0d",
               checks, errors, completed, issued);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire
